//--- ddr_wr_path_pkg.sv
/*
 * Shared widths, types and FSM encoding for the DDR write datapath.
 * Fixed at eight DQ pins and two beats per clk cycle.
 * A burst is always four clk cycles (eight beats) long.
 */

package ddr_wr_path_pkg;

	// ****************************************
	// pin and burst geometry
	// ****************************************

	// number of DQ pins
	localparam int dq_width = 8;
	// beats per clk cycle at the DDR pins
	localparam int beats_per_clk = 2;
	// clk cycles per burst
	localparam int burst_clks = 4;
	localparam int burst_cnt_w = $clog2(burst_clks);

	// ****************************************
	// vector types
	// ****************************************

	// one beat on the DQ pins
	typedef logic [dq_width-1:0] beat_t;
	// one core word, the low beat goes out first
	typedef logic [beats_per_clk*dq_width-1:0] word_t;
	// one DM bit per beat
	typedef logic [beats_per_clk-1:0] mask_t;
	// two beats of a single pin such as DQS
	typedef logic [beats_per_clk-1:0] pair_t;
	// beat-pair position inside a burst
	typedef logic [burst_cnt_w-1:0] burst_cnt_t;

	// last beat pair of a burst
	localparam burst_cnt_t burst_last = burst_cnt_t'(burst_clks - 1);

	// dqs high in the clk-high phase, low in the clk-low phase
	localparam pair_t dqs_data_pat = 2'b01;
	// dqs held low in preamble, postamble and idle
	localparam pair_t dqs_quiet = 2'b00;

	// write burst FSM, state follows the phase seen on the pins
	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_pre  = 2'd1,
		st_data = 2'd2,
		st_post = 2'd3
	} wr_state_t;

endpackage

//--- ddio_out.sv
/*
 * Soft-logic DDR output: two beats in per clk rise, one pin per bit out.
 * The low half is driven while clk is high, the high half while clk is low.
 * Output is combinational on clk, so pins carry mux glitches at clk edges.
 */

`timescale 1ns/1ps

module ddio_out #(
	parameter int width = 1
) (
	input  logic               clk,
	input  logic               dr_reset_n,
	input  logic [2*width-1:0] datain,
	output logic [width-1:0]   dataout
);

	// ****************************************
	// input register
	// ****************************************

	// both beats captured together on the rising edge
	logic [2*width-1:0] datain_r;

	always_ff @(posedge clk or negedge dr_reset_n) begin
		if (!dr_reset_n) begin
			// pins come out of reset low
			datain_r <= '0;
		end else begin
			datain_r <= datain;
		end
	end

	// ****************************************
	// phase mux
	// ****************************************

	// split the registered pair into its two beats
	logic [width-1:0] beat_lo;
	logic [width-1:0] beat_hi;

	assign beat_lo = datain_r[width-1:0];
	assign beat_hi = datain_r[2*width-1:width];

	// one 2:1 mux per pin, select is the clock itself
	// beat_lo leads, it is valid from the rising edge
	// beat_hi follows, it is valid from the falling edge
	genvar i;
	generate
		for (i = 0; i < width; i++) begin : g_bit
			always_comb begin
				if (clk) begin
					dataout[i] = beat_lo[i];
				end else begin
					dataout[i] = beat_hi[i];
				end
			end
		end
	endgenerate

	// timing seen on a pin for a pair registered at rise n
	//   clk high after rise n  -> datain[i]
	//   clk low after fall n   -> datain[width+i]
	// the pin thus lags the core word by one clk cycle

endmodule

//--- wr_burst_ctrl.sv
/*
 * Write burst framing for the DDR PHY.
 * Expects bursts of exactly four back-to-back wr_valid cycles.
 * Bursts either join directly or are separated by at least two idle cycles.
 * A one-cycle gap is not supported and corrupts the framing.
 */

`timescale 1ns/1ps

module wr_burst_ctrl (
	input  logic                       clk,
	input  logic                       dr_reset_n,
	input  logic                       wr_valid,
	input  ddr_wr_path_pkg::word_t     wr_data,
	input  ddr_wr_path_pkg::mask_t     wr_mask,
	output ddr_wr_path_pkg::word_t     dq_pair,
	output ddr_wr_path_pkg::mask_t     dm_pair,
	output ddr_wr_path_pkg::pair_t     dqs_pair,
	output logic                       dq_oe,
	output logic                       dqs_oe
);

	// ****************************************
	// data delay stage
	// ****************************************

	// one extra register so the preamble can lead the data
	logic                   valid_d;
	ddr_wr_path_pkg::word_t data_d;
	ddr_wr_path_pkg::mask_t mask_d;

	always_ff @(posedge clk or negedge dr_reset_n) begin
		if (!dr_reset_n) begin
			valid_d <= 1'b0;
			data_d  <= '0;
			mask_d  <= '0;
		end else begin
			valid_d <= wr_valid;
			// bus parks at zero between bursts
			data_d  <= wr_valid ? wr_data : '0;
			mask_d  <= wr_valid ? wr_mask : '0;
		end
	end

	// ****************************************
	// burst FSM
	// ****************************************

	// state after a rising edge matches what the pins show in that cycle
	ddr_wr_path_pkg::wr_state_t  state;
	ddr_wr_path_pkg::wr_state_t  state_nxt;
	ddr_wr_path_pkg::burst_cnt_t cnt;

	always_comb begin
		state_nxt = state;
		case (state)
			ddr_wr_path_pkg::st_idle: begin
				// first word of a burst has reached the delay stage
				if (valid_d) begin
					state_nxt = ddr_wr_path_pkg::st_pre;
				end
			end
			ddr_wr_path_pkg::st_pre: begin
				// preamble lasts exactly one cycle
				state_nxt = ddr_wr_path_pkg::st_data;
			end
			ddr_wr_path_pkg::st_data: begin
				if (cnt == ddr_wr_path_pkg::burst_last) begin
					// next burst already in the pipeline, join without a gap
					if (valid_d) begin
						state_nxt = ddr_wr_path_pkg::st_data;
					end else begin
						state_nxt = ddr_wr_path_pkg::st_post;
					end
				end
			end
			ddr_wr_path_pkg::st_post: begin
				// two idle cycles allow a new preamble right after the postamble
				if (valid_d) begin
					state_nxt = ddr_wr_path_pkg::st_pre;
				end else begin
					state_nxt = ddr_wr_path_pkg::st_idle;
				end
			end
			default: begin
				state_nxt = ddr_wr_path_pkg::st_idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge dr_reset_n) begin
		if (!dr_reset_n) begin
			state <= ddr_wr_path_pkg::st_idle;
			cnt   <= '0;
		end else begin
			state <= state_nxt;
			// counts beat pairs on the pins, wraps into the next joined burst
			if (state == ddr_wr_path_pkg::st_data) begin
				cnt <= ddr_wr_path_pkg::burst_cnt_t'(cnt + 1'b1);
			end else begin
				cnt <= '0;
			end
		end
	end

	// ****************************************
	// pin-side registers
	// ****************************************

	// pairs lead the pins by one cycle for the ddio_out register
	// enables go straight to the pins so they follow state_nxt directly
	always_ff @(posedge clk or negedge dr_reset_n) begin
		if (!dr_reset_n) begin
			dq_pair  <= '0;
			dm_pair  <= '0;
			dqs_pair <= ddr_wr_path_pkg::dqs_quiet;
			dq_oe    <= 1'b0;
			dqs_oe   <= 1'b0;
		end else begin
			dq_pair  <= data_d;
			dm_pair  <= mask_d;
			// strobe toggles only for pairs that carry burst data
			if (valid_d) begin
				dqs_pair <= ddr_wr_path_pkg::dqs_data_pat;
			end else begin
				dqs_pair <= ddr_wr_path_pkg::dqs_quiet;
			end
			dq_oe  <= (state_nxt == ddr_wr_path_pkg::st_data);
			// dqs driven through preamble, data and postamble
			dqs_oe <= (state_nxt != ddr_wr_path_pkg::st_idle);
		end
	end

endmodule

//--- ddr_wr_path.sv
/*
 * DDR PHY write datapath top: burst framing plus DQ, DM and DQS rate doublers.
 * Write data shows up on dq two clk cycles after its wr_valid edge.
 * Output enables are level signals that change only at clk rise.
 */

`timescale 1ns/1ps

module ddr_wr_path (
	input  logic                   clk,
	input  logic                   dr_reset_n,
	input  logic                   wr_valid,
	input  ddr_wr_path_pkg::word_t wr_data,
	input  ddr_wr_path_pkg::mask_t wr_mask,
	output ddr_wr_path_pkg::beat_t dq,
	output logic                   dm,
	output logic                   dqs,
	output logic                   dq_oe,
	output logic                   dqs_oe
);

	// ****************************************
	// burst controller
	// ****************************************

	ddr_wr_path_pkg::word_t dq_pair;
	ddr_wr_path_pkg::mask_t dm_pair;
	ddr_wr_path_pkg::pair_t dqs_pair;

	// enables are registered inside, no further stage here
	wr_burst_ctrl u_ctrl (
		.clk        (clk),
		.dr_reset_n (dr_reset_n),
		.wr_valid   (wr_valid),
		.wr_data    (wr_data),
		.wr_mask    (wr_mask),
		.dq_pair    (dq_pair),
		.dm_pair    (dm_pair),
		.dqs_pair   (dqs_pair),
		.dq_oe      (dq_oe),
		.dqs_oe     (dqs_oe)
	);

	// ****************************************
	// rate doublers
	// ****************************************

	// all eight dq pins share one instance
	ddio_out #(.width(ddr_wr_path_pkg::dq_width)) u_dq (
		.clk        (clk),
		.dr_reset_n (dr_reset_n),
		.datain     (dq_pair),
		.dataout    (dq)
	);

	ddio_out #(.width(1)) u_dm (
		.clk        (clk),
		.dr_reset_n (dr_reset_n),
		.datain     (dm_pair),
		.dataout    (dm)
	);

	// same path as the data so dqs stays edge aligned with dq
	ddio_out #(.width(1)) u_dqs (
		.clk        (clk),
		.dr_reset_n (dr_reset_n),
		.datain     (dqs_pair),
		.dataout    (dqs)
	);

endmodule

//--- ddr_wr_path_properties.sv
/*
 * Protocol checks on the write burst controller, bound into wr_burst_ctrl.
 * Run-length checks count modulo four, so they assume four-cycle bursts.
 */

`timescale 1ns/1ps

module ddr_wr_path_properties (
	input logic clk,
	input logic dr_reset_n,
	input logic wr_valid,
	input logic dq_oe,
	input logic dqs_oe
);

	// number of failed checks, read at the end of the run
	int fail_count = 0;

	// run lengths modulo burst_clks
	ddr_wr_path_pkg::burst_cnt_t valid_run;
	ddr_wr_path_pkg::burst_cnt_t oe_run;

	always_ff @(posedge clk or negedge dr_reset_n) begin
		if (!dr_reset_n) begin
			valid_run <= '0;
			oe_run    <= '0;
		end else begin
			valid_run <= wr_valid ? ddr_wr_path_pkg::burst_cnt_t'(valid_run + 1'b1) : '0;
			oe_run    <= dq_oe ? ddr_wr_path_pkg::burst_cnt_t'(oe_run + 1'b1) : '0;
		end
	end

	// data is never driven without its strobe
	a_dq_needs_dqs: assert property (@(posedge clk) disable iff (!dr_reset_n)
		dq_oe |-> dqs_oe)
		else begin
			fail_count++;
			$error("dq_oe high while dqs_oe is low");
		end

	// preamble is exactly one cycle
	a_pre_lead: assert property (@(posedge clk) disable iff (!dr_reset_n)
		$rose(dqs_oe) |=> $rose(dq_oe))
		else begin
			fail_count++;
			$error("dq_oe did not follow dqs_oe by one cycle");
		end

	a_pre_before_data: assert property (@(posedge clk) disable iff (!dr_reset_n)
		$rose(dq_oe) |-> $past(dqs_oe))
		else begin
			fail_count++;
			$error("dq_oe rose without a preamble cycle");
		end

	a_oe_run: assert property (@(posedge clk) disable iff (!dr_reset_n)
		$fell(dq_oe) |-> oe_run == '0)
		else begin
			fail_count++;
			$error("dq_oe run is not a whole number of bursts");
		end

	a_valid_run: assert property (@(posedge clk) disable iff (!dr_reset_n)
		$fell(wr_valid) |-> valid_run == '0)
		else begin
			fail_count++;
			$error("wr_valid run is not a whole number of bursts");
		end

endmodule

bind wr_burst_ctrl ddr_wr_path_properties u_properties (
	.clk        (clk),
	.dr_reset_n (dr_reset_n),
	.wr_valid   (wr_valid),
	.dq_oe      (dq_oe),
	.dqs_oe     (dqs_oe)
);

//--- ddr_wr_path_tb.sv
/*
 * Trace-driven testbench for the DDR write datapath.
 * Inputs change on the falling edge and pins are checked once per clk phase.
 * The trace already holds expected pins shifted by the two-cycle latency.
 */

`timescale 1ns/1ps

module ddr_wr_path_tb;

	// trace columns, one row per clk cycle, a row with test id ff ends the trace
	localparam int fields = 10;
	localparam int max_rows = 256;
	localparam int col_test = 0;
	localparam int col_valid = 1;
	localparam int col_data = 2;
	localparam int col_mask = 3;
	localparam int col_dq_lo = 4;
	localparam int col_dq_hi = 5;
	localparam int col_dm = 6;
	localparam int col_dqs = 7;
	localparam int col_dq_oe = 8;
	localparam int col_dqs_oe = 9;
	localparam logic [31:0] end_mark = 32'hff;
	localparam real clk_period = 4.0;
	// sampling point, just ahead of the next clk edge
	localparam real sample_ofs = 1.5;
	localparam int reset_cycles = 5;

	logic                   clk;
	logic                   dr_reset_n;
	logic                   wr_valid;
	ddr_wr_path_pkg::word_t wr_data;
	ddr_wr_path_pkg::mask_t wr_mask;
	ddr_wr_path_pkg::beat_t dq;
	logic                   dm;
	logic                   dqs;
	logic                   dq_oe;
	logic                   dqs_oe;

	logic [31:0] trace_mem [0:max_rows*fields-1];
	int          n_rows = 0;
	logic        trace_loaded = 1'b0;

	// generator state for the filler driven between words
	int unsigned lcg_state = 32'd92;

	ddr_wr_path u_ddr_wr_path (
		.clk        (clk),
		.dr_reset_n (dr_reset_n),
		.wr_valid   (wr_valid),
		.wr_data    (wr_data),
		.wr_mask    (wr_mask),
		.dq         (dq),
		.dm         (dm),
		.dqs        (dqs),
		.dq_oe      (dq_oe),
		.dqs_oe     (dqs_oe)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2.0) clk = ~clk;
	end

	// ****************************************
	// trace access and drive
	// ****************************************

	function automatic logic [31:0] trace_field(input int row, input int col);
		return trace_mem[row*fields + col];
	endfunction

	function automatic string test_name(input int row);
		case (trace_field(row, col_test))
			32'd1: return "reset_idle";
			32'd2: return "single_burst";
			32'd3: return "gapped_burst";
			32'd4: return "back_to_back";
			default: return "unknown";
		endcase
	endfunction

	// linear congruential step, upper bits are the useful ones
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic drive_idle();
		wr_valid = 1'b0;
		wr_data  = '0;
		wr_mask  = '0;
	endtask

	task automatic drive_row(input int row);
		logic [31:0] filler;
		filler   = lcg_next();
		wr_valid = 1'(trace_field(row, col_valid));
		if (wr_valid) begin
			wr_data = ddr_wr_path_pkg::word_t'(trace_field(row, col_data));
			wr_mask = ddr_wr_path_pkg::mask_t'(trace_field(row, col_mask));
		end else begin
			// data and mask are don't care between words and must not reach the pins
			wr_data = filler[31:16];
			wr_mask = filler[15:14];
		end
	endtask

	// ****************************************
	// compare tasks
	// ****************************************

	task automatic check_beat(input string name, input ddr_wr_path_pkg::beat_t exp,
		input ddr_wr_path_pkg::beat_t act);
		if (act !== exp) begin
			$display("Error: %s expected %h actual %h", name, exp, act);
			$display("RESULT: FAIL");
			$fatal(1, "dq beat mismatch");
		end
	endtask

	// bit 0 is the clk-high phase, bit 1 the clk-low phase
	task automatic check_pair(input string name, input ddr_wr_path_pkg::pair_t exp,
		input ddr_wr_path_pkg::pair_t act);
		if (act !== exp) begin
			$display("Error: %s expected %b actual %b", name, exp, act);
			$display("RESULT: FAIL");
			$fatal(1, "pin pair mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error: %s expected %b actual %b", name, exp, act);
			$display("RESULT: FAIL");
			$fatal(1, "output enable mismatch");
		end
	endtask

	// ****************************************
	// main sequence and watchdog
	// ****************************************

	initial begin : run_trace
		int                     row;
		string                  tag;
		ddr_wr_path_pkg::pair_t dm_seen;
		ddr_wr_path_pkg::pair_t dqs_seen;
		dr_reset_n = 1'b0;
		drive_idle();
		$readmemh("ddr_wr_path_trace.txt", trace_mem);
		while (n_rows < max_rows && trace_field(n_rows, col_test) != end_mark) begin
			n_rows++;
		end
		if (n_rows == 0 || n_rows == max_rows) begin
			$display("trace file is missing, empty or lacks its end row");
			$display("RESULT: FAIL");
			$fatal(1, "no usable trace");
		end
		trace_loaded = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		dr_reset_n = 1'b1;
		drive_row(0);
		for (row = 0; row < n_rows; row++) begin
			tag = $sformatf("%s row %0d", test_name(row), row);
			@(posedge clk);
			#(sample_ofs);
			// clk high, pins carry the low beat
			check_beat({tag, " dq low beat"},
				ddr_wr_path_pkg::beat_t'(trace_field(row, col_dq_lo)), dq);
			dm_seen[0]  = dm;
			dqs_seen[0] = dqs;
			@(negedge clk);
			if (row + 1 < n_rows) begin
				drive_row(row + 1);
			end else begin
				drive_idle();
			end
			#(sample_ofs);
			// clk low, high beat on the pins, enables settled for the whole cycle
			check_beat({tag, " dq high beat"},
				ddr_wr_path_pkg::beat_t'(trace_field(row, col_dq_hi)), dq);
			dm_seen[1]  = dm;
			dqs_seen[1] = dqs;
			check_pair({tag, " dm"}, ddr_wr_path_pkg::pair_t'(trace_field(row, col_dm)),
				dm_seen);
			check_pair({tag, " dqs"}, ddr_wr_path_pkg::pair_t'(trace_field(row, col_dqs)),
				dqs_seen);
			check_bit({tag, " dq_oe"}, 1'(trace_field(row, col_dq_oe)), dq_oe);
			check_bit({tag, " dqs_oe"}, 1'(trace_field(row, col_dqs_oe)), dqs_oe);
		end
		if (u_ddr_wr_path.u_ctrl.u_properties.fail_count != 0) begin
			$display("bound protocol checks failed %0d times",
				u_ddr_wr_path.u_ctrl.u_properties.fail_count);
			$display("RESULT: FAIL");
			$fatal(1, "protocol check failures");
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

	// run length follows the trace, with slack for reset and pipeline drain
	initial begin : watchdog
		wait (trace_loaded);
		#((n_rows + 20) * clk_period);
		$display("simulation ran past its time limit before the trace finished");
		$display("RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- ddr_wr_path_trace.txt
// test valid data mask | expected dq_lo dq_hi dm dqs dq_oe dqs_oe, all hex
// test ids 1 reset_idle, 2 single_burst, 3 gapped_burst, 4 back_to_back, ff ends
1 0 0000 0  00 00 0 0 0 0
1 0 0000 0  00 00 0 0 0 0
1 0 0000 0  00 00 0 0 0 0
2 1 2211 0  00 00 0 0 0 0
2 1 4433 1  00 00 0 0 0 1
2 1 6655 2  11 22 0 1 1 1
2 1 8877 0  33 44 1 1 1 1
2 0 0000 0  55 66 2 1 1 1
2 0 0000 0  77 88 0 1 1 1
3 1 a55a 3  00 00 0 0 0 1
3 1 c33c 0  00 00 0 0 0 1
3 1 0ff0 0  5a a5 3 1 1 1
3 1 9669 2  3c c3 0 1 1 1
3 0 0000 0  f0 0f 0 1 1 1
3 0 0000 0  69 96 2 1 1 1
3 0 0000 0  00 00 0 0 0 1
3 0 0000 0  00 00 0 0 0 0
4 1 1201 0  00 00 0 0 0 0
4 1 3423 1  00 00 0 0 0 1
4 1 5645 0  01 12 0 1 1 1
4 1 7867 0  23 34 1 1 1 1
4 1 9a89 2  45 56 0 1 1 1
4 1 bcab 0  67 78 0 1 1 1
4 1 decd 1  89 9a 2 1 1 1
4 1 f0ef 0  ab bc 0 1 1 1
4 0 0000 0  cd de 1 1 1 1
4 0 0000 0  ef f0 0 1 1 1
4 0 0000 0  00 00 0 0 0 1
4 0 0000 0  00 00 0 0 0 0
4 0 0000 0  00 00 0 0 0 0
ff 0 0000 0  00 00 0 0 0 0

//--- ddr_wr_path.f
ddr_wr_path_pkg.sv
ddio_out.sv
wr_burst_ctrl.sv
ddr_wr_path.sv
ddr_wr_path_properties.sv
ddr_wr_path_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f ddr_wr_path.f --top-module ddr_wr_path_tb -o ddr_wr_path_sim
	./obj_dir/ddr_wr_path_sim

clean:
	rm -rf obj_dir
